/* Makefile */
TOP = tb_soc_mem_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "TB FAILED" >> sim.log
	cat sim.log
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/bus_interconnect.sv */
`default_nettype none

module bus_interconnect (
  input wire clk_pll,
  input wire rst,
  input wire imem_valid_i,
  input wire [31:0] imem_addr_i,
  input wire [31:0] imem_wdata_i,
  input wire [3:0] imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic imem_ready_o,
  input wire dmem_valid_i,
  input wire [31:0] dmem_addr_i,
  input wire [31:0] dmem_wdata_i,
  input wire [3:0] dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic dmem_ready_o,
  output logic iram_valid_o,
  output logic [31:0] iram_addr_o,
  output logic [31:0] iram_wdata_o,
  output logic [3:0] iram_wstrb_o,
  input wire [31:0] iram_rdata_i,
  input wire iram_ready_i,
  output logic dram_valid_o,
  output logic [31:0] dram_addr_o,
  output logic [31:0] dram_wdata_o,
  output logic [3:0] dram_wstrb_o,
  input wire [31:0] dram_rdata_i,
  input wire dram_ready_i,
  output logic timer_valid_o,
  output logic [31:0] timer_addr_o,
  output logic [31:0] timer_wdata_o,
  output logic [3:0] timer_wstrb_o,
  input wire [31:0] timer_rdata_i,
  input wire timer_ready_i
);

  soc_pkg::bus_target_e i_tgt, d_tgt;
  soc_pkg::bus_target_e i_rel, d_rel; // release target, TGT_NONE when idle.
  logic i_pend, d_pend;
  logic i_req, d_req;
  logic i_acc, d_acc;
  logic [2:0] busy;
  logic d_iram, d_dram, d_timer;
  logic i_iram, i_dram, i_timer;

  function automatic soc_pkg::bus_target_e decode(input logic [31:0] addr);
    if (addr >= soc_pkg::TIMER_BASE && addr < soc_pkg::TIMER_TOP) begin
      return soc_pkg::TGT_TIMER;
    end else if (addr >= soc_pkg::DRAM_BASE && addr < soc_pkg::DRAM_TOP) begin
      return soc_pkg::TGT_DRAM;
    end else if (addr >= soc_pkg::IRAM_BASE && addr < soc_pkg::IRAM_TOP) begin
      return soc_pkg::TGT_IRAM;
    end
    return soc_pkg::TGT_NONE;
  endfunction

  function automatic logic is_free(input soc_pkg::bus_target_e tgt, input logic [2:0] bsy);
    if (tgt == soc_pkg::TGT_NONE) begin
      return 1'b1;
    end
    return ~bsy[tgt];
  endfunction

  assign i_tgt = decode(imem_addr_i);
  assign d_tgt = decode(dmem_addr_i);

  // a target answering this cycle cannot take a new pulse.
  assign busy[0] = (i_rel == soc_pkg::TGT_IRAM) | (d_rel == soc_pkg::TGT_IRAM);
  assign busy[1] = (i_rel == soc_pkg::TGT_DRAM) | (d_rel == soc_pkg::TGT_DRAM);
  assign busy[2] = (i_rel == soc_pkg::TGT_TIMER) | (d_rel == soc_pkg::TGT_TIMER);

  assign d_req = dmem_valid_i & ~d_pend;
  assign i_req = imem_valid_i & ~i_pend;
  assign d_acc = d_req & is_free(d_tgt, busy);
  // data port wins on a shared real target.
  assign i_acc = i_req & is_free(i_tgt, busy) &
                 ~(d_req & (d_tgt == i_tgt) & (i_tgt != soc_pkg::TGT_NONE));

  assign d_iram = d_acc & (d_tgt == soc_pkg::TGT_IRAM);
  assign d_dram = d_acc & (d_tgt == soc_pkg::TGT_DRAM);
  assign d_timer = d_acc & (d_tgt == soc_pkg::TGT_TIMER);
  assign i_iram = i_acc & (i_tgt == soc_pkg::TGT_IRAM);
  assign i_dram = i_acc & (i_tgt == soc_pkg::TGT_DRAM);
  assign i_timer = i_acc & (i_tgt == soc_pkg::TGT_TIMER);

  assign iram_valid_o = d_iram | i_iram;
  assign iram_addr_o = d_iram ? dmem_addr_i - soc_pkg::IRAM_BASE : imem_addr_i - soc_pkg::IRAM_BASE;
  assign iram_wdata_o = d_iram ? dmem_wdata_i : imem_wdata_i;
  assign iram_wstrb_o = d_iram ? dmem_wstrb_i : imem_wstrb_i;

  assign dram_valid_o = d_dram | i_dram;
  assign dram_addr_o = d_dram ? dmem_addr_i - soc_pkg::DRAM_BASE : imem_addr_i - soc_pkg::DRAM_BASE;
  assign dram_wdata_o = d_dram ? dmem_wdata_i : imem_wdata_i;
  assign dram_wstrb_o = d_dram ? dmem_wstrb_i : imem_wstrb_i;

  assign timer_valid_o = d_timer | i_timer;
  assign timer_addr_o = d_timer ? dmem_addr_i - soc_pkg::TIMER_BASE :
                                  imem_addr_i - soc_pkg::TIMER_BASE;
  assign timer_wdata_o = d_timer ? dmem_wdata_i : imem_wdata_i;
  assign timer_wstrb_o = d_timer ? dmem_wstrb_i : imem_wstrb_i;

  always_comb begin
    case (i_rel)
      soc_pkg::TGT_IRAM: {imem_ready_o, imem_rdata_o} = {iram_ready_i, iram_rdata_i};
      soc_pkg::TGT_DRAM: {imem_ready_o, imem_rdata_o} = {dram_ready_i, dram_rdata_i};
      soc_pkg::TGT_TIMER: {imem_ready_o, imem_rdata_o} = {timer_ready_i, timer_rdata_i};
      default: {imem_ready_o, imem_rdata_o} = {i_pend, 32'h0}; // dummy reply.
    endcase
    case (d_rel)
      soc_pkg::TGT_IRAM: {dmem_ready_o, dmem_rdata_o} = {iram_ready_i, iram_rdata_i};
      soc_pkg::TGT_DRAM: {dmem_ready_o, dmem_rdata_o} = {dram_ready_i, dram_rdata_i};
      soc_pkg::TGT_TIMER: {dmem_ready_o, dmem_rdata_o} = {timer_ready_i, timer_rdata_i};
      default: {dmem_ready_o, dmem_rdata_o} = {d_pend, 32'h0};
    endcase
  end

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      i_pend <= 1'b0;
      d_pend <= 1'b0;
      i_rel <= soc_pkg::TGT_NONE;
      d_rel <= soc_pkg::TGT_NONE;
    end else begin
      if (i_acc) begin
        i_pend <= 1'b1;
        i_rel <= i_tgt;
      end else if (imem_ready_o) begin
        i_pend <= 1'b0;
        i_rel <= soc_pkg::TGT_NONE;
      end
      if (d_acc) begin
        d_pend <= 1'b1;
        d_rel <= d_tgt;
      end else if (dmem_ready_o) begin
        d_pend <= 1'b0;
        d_rel <= soc_pkg::TGT_NONE;
      end
    end
  end

  a_one_master_per_target: assert property (@(posedge clk_pll) disable iff (!rst)
    !((d_iram & i_iram) | (d_dram & i_dram) | (d_timer & i_timer)));

  a_imem_ready_pending: assert property (@(posedge clk_pll) disable iff (!rst)
    imem_ready_o |-> i_pend);

  a_dmem_ready_pending: assert property (@(posedge clk_pll) disable iff (!rst)
    dmem_ready_o |-> d_pend);

endmodule

`default_nettype wire

/* hdl/machine_timer.sv */
`default_nettype none

module machine_timer (
  input wire clk_pll,
  input wire rst,
  input wire valid_i,
  input wire [31:0] addr_i,
  input wire [31:0] wdata_i,
  input wire [3:0] wstrb_i,
  output logic [31:0] rdata_o,
  output logic ready_o,
  output logic timer_irq_o
);

  logic [63:0] mtime, mtime_nxt;
  logic [63:0] mtimecmp, cmp_nxt;
  logic wen;

  function automatic logic [31:0] merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                        input logic [3:0] strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wen = valid_i & (|wstrb_i);

  always_comb begin
    mtime_nxt = mtime + 64'd1;
    cmp_nxt = mtimecmp;
    if (wen) begin
      case (addr_i)
        soc_pkg::TIMER_MTIME_LO: mtime_nxt[31:0] = merge(mtime[31:0], wdata_i, wstrb_i);
        soc_pkg::TIMER_MTIME_HI: mtime_nxt[63:32] = merge(mtime[63:32], wdata_i, wstrb_i);
        soc_pkg::TIMER_CMP_LO: cmp_nxt[31:0] = merge(mtimecmp[31:0], wdata_i, wstrb_i);
        soc_pkg::TIMER_CMP_HI: cmp_nxt[63:32] = merge(mtimecmp[63:32], wdata_i, wstrb_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      mtime <= 64'd0;
      mtimecmp <= '1; // no interrupt until software sets a compare value.
      ready_o <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      mtime <= mtime_nxt;
      mtimecmp <= cmp_nxt;
      ready_o <= valid_i;
      timer_irq_o <= (mtime >= mtimecmp);
    end
  end

  always_ff @(posedge clk_pll) begin
    if (valid_i) begin
      case (addr_i)
        soc_pkg::TIMER_MTIME_LO: rdata_o <= mtime[31:0];
        soc_pkg::TIMER_MTIME_HI: rdata_o <= mtime[63:32];
        soc_pkg::TIMER_CMP_LO: rdata_o <= mtimecmp[31:0];
        soc_pkg::TIMER_CMP_HI: rdata_o <= mtimecmp[63:32];
        default: rdata_o <= 32'h0;
      endcase
    end
  end

  a_irq_known: assert property (@(posedge clk_pll) disable iff (!rst)
    !$isunknown(timer_irq_o));

endmodule

`default_nettype wire

/* hdl/soc_mem_top.sv */
`default_nettype none

module soc_mem_top (
  input wire clk_pll,
  input wire rst,
  input wire imem_valid_i,
  input wire [31:0] imem_addr_i,
  input wire [31:0] imem_wdata_i,
  input wire [3:0] imem_wstrb_i,
  output logic [31:0] imem_rdata_o,
  output logic imem_ready_o,
  input wire dmem_valid_i,
  input wire [31:0] dmem_addr_i,
  input wire [31:0] dmem_wdata_i,
  input wire [3:0] dmem_wstrb_i,
  output logic [31:0] dmem_rdata_o,
  output logic dmem_ready_o,
  output logic timer_irq_o
);

  logic iram_valid, dram_valid, timer_valid;
  logic iram_ready, dram_ready, timer_ready;
  logic [31:0] iram_addr, dram_addr, timer_addr;
  logic [31:0] iram_wdata, dram_wdata, timer_wdata;
  logic [3:0] iram_wstrb, dram_wstrb, timer_wstrb;
  logic [31:0] iram_rdata, dram_rdata, timer_rdata;

  bus_interconnect u_bus_interconnect (
    .clk_pll (clk_pll),
    .rst (rst),
    .imem_valid_i (imem_valid_i),
    .imem_addr_i (imem_addr_i),
    .imem_wdata_i (imem_wdata_i),
    .imem_wstrb_i (imem_wstrb_i),
    .imem_rdata_o (imem_rdata_o),
    .imem_ready_o (imem_ready_o),
    .dmem_valid_i (dmem_valid_i),
    .dmem_addr_i (dmem_addr_i),
    .dmem_wdata_i (dmem_wdata_i),
    .dmem_wstrb_i (dmem_wstrb_i),
    .dmem_rdata_o (dmem_rdata_o),
    .dmem_ready_o (dmem_ready_o),
    .iram_valid_o (iram_valid),
    .iram_addr_o (iram_addr),
    .iram_wdata_o (iram_wdata),
    .iram_wstrb_o (iram_wstrb),
    .iram_rdata_i (iram_rdata),
    .iram_ready_i (iram_ready),
    .dram_valid_o (dram_valid),
    .dram_addr_o (dram_addr),
    .dram_wdata_o (dram_wdata),
    .dram_wstrb_o (dram_wstrb),
    .dram_rdata_i (dram_rdata),
    .dram_ready_i (dram_ready),
    .timer_valid_o (timer_valid),
    .timer_addr_o (timer_addr),
    .timer_wdata_o (timer_wdata),
    .timer_wstrb_o (timer_wstrb),
    .timer_rdata_i (timer_rdata),
    .timer_ready_i (timer_ready)
  );

  sram_block #(
    .DEPTH (soc_pkg::IRAM_DEPTH)
  ) u_iram (
    .clk_pll (clk_pll),
    .rst (rst),
    .valid_i (iram_valid),
    .addr_i (iram_addr),
    .wdata_i (iram_wdata),
    .wstrb_i (iram_wstrb),
    .rdata_o (iram_rdata),
    .ready_o (iram_ready)
  );

  sram_block #(
    .DEPTH (soc_pkg::DRAM_DEPTH)
  ) u_dram (
    .clk_pll (clk_pll),
    .rst (rst),
    .valid_i (dram_valid),
    .addr_i (dram_addr),
    .wdata_i (dram_wdata),
    .wstrb_i (dram_wstrb),
    .rdata_o (dram_rdata),
    .ready_o (dram_ready)
  );

  machine_timer u_machine_timer (
    .clk_pll (clk_pll),
    .rst (rst),
    .valid_i (timer_valid),
    .addr_i (timer_addr),
    .wdata_i (timer_wdata),
    .wstrb_i (timer_wstrb),
    .rdata_o (timer_rdata),
    .ready_o (timer_ready),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  // address map, byte addresses with exclusive top.
  localparam logic [31:0] IRAM_BASE = 32'h0000_0000;
  localparam logic [31:0] IRAM_TOP = 32'h0000_0400;

  localparam logic [31:0] DRAM_BASE = 32'h0001_0000;
  localparam logic [31:0] DRAM_TOP = 32'h0001_0400;

  localparam logic [31:0] TIMER_BASE = 32'h0002_0000;
  localparam logic [31:0] TIMER_TOP = 32'h0002_0010;

  // ram sizes in 32-bit words.
  localparam int IRAM_DEPTH = 256;
  localparam int DRAM_DEPTH = 256;

  // timer register offsets, local to TIMER_BASE.
  localparam logic [31:0] TIMER_MTIME_LO = 32'h0000_0000;
  localparam logic [31:0] TIMER_MTIME_HI = 32'h0000_0004;
  localparam logic [31:0] TIMER_CMP_LO = 32'h0000_0008;
  localparam logic [31:0] TIMER_CMP_HI = 32'h0000_000c;

  // routing target of a request.
  typedef enum logic [1:0] {
    TGT_IRAM = 2'd0,
    TGT_DRAM = 2'd1,
    TGT_TIMER = 2'd2,
    TGT_NONE = 2'd3 // unmapped, answered by the interconnect.
  } bus_target_e;

endpackage

`default_nettype wire

/* hdl/sram_block.sv */
`default_nettype none

module sram_block #(
  parameter int DEPTH = 256
) (
  input wire clk_pll,
  input wire rst,
  input wire valid_i,
  input wire [31:0] addr_i,
  input wire [31:0] wdata_i,
  input wire [3:0] wstrb_i,
  output logic [31:0] rdata_o,
  output logic ready_o
);

  logic [31:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] idx;
  logic wen;

  assign idx = addr_i[$clog2(DEPTH)+1:2]; // word index.
  assign wen = valid_i & (|wstrb_i);

  always_ff @(posedge clk_pll) begin
    if (valid_i) begin
      rdata_o <= mem[idx]; // old word on a write.
    end
    if (wen) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_pll) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= valid_i;
    end
  end

  a_valid_pulse: assert property (@(posedge clk_pll) disable iff (!rst)
    valid_i |=> !valid_i);

endmodule

`default_nettype wire

/* tb/tb_soc_mem_top.sv */
`default_nettype none

module tb_soc_mem_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 4000; // about four times the full test sequence.

  logic clk_pll = 1'b0;
  logic rst;
  logic imem_valid, dmem_valid;
  logic [31:0] imem_addr, imem_wdata, dmem_addr, dmem_wdata;
  logic [3:0] imem_wstrb, dmem_wstrb;
  logic [31:0] imem_rdata_o, dmem_rdata_o;
  logic imem_ready_o, dmem_ready_o, timer_irq_o;

  logic [31:0] iram_shadow [256];
  logic [31:0] dram_shadow [256];
  logic [31:0] rd_addr_q [$];
  logic [31:0] rd_data_q [$];
  string rd_name_q [$];
  logic [31:0] rng_state = 32'h5cdc_4ccd;
  int cycle = 0;
  int checks = 0;
  int errors = 0;
  int test_errs = 0;

  soc_mem_top u_soc_mem_top (
    .clk_pll (clk_pll),
    .rst (rst),
    .imem_valid_i (imem_valid),
    .imem_addr_i (imem_addr),
    .imem_wdata_i (imem_wdata),
    .imem_wstrb_i (imem_wstrb),
    .imem_rdata_o (imem_rdata_o),
    .imem_ready_o (imem_ready_o),
    .dmem_valid_i (dmem_valid),
    .dmem_addr_i (dmem_addr),
    .dmem_wdata_i (dmem_wdata),
    .dmem_wstrb_i (dmem_wstrb),
    .dmem_rdata_o (dmem_rdata_o),
    .dmem_ready_o (dmem_ready_o),
    .timer_irq_o (timer_irq_o)
  );

  always #2 clk_pll = ~clk_pll;

  function automatic logic [31:0] xorshift_next();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic bit in_range(input logic [31:0] addr, input logic [31:0] base,
                                  input logic [31:0] top);
    return (addr - base) < (top - base); // wraps below base.
  endfunction

  // expected read word: shadow contents in ram ranges, zero when unmapped.
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] off;
    if (in_range(addr, soc_pkg::IRAM_BASE, soc_pkg::IRAM_TOP)) begin
      off = addr - soc_pkg::IRAM_BASE;
      return iram_shadow[off[9:2]];
    end else if (in_range(addr, soc_pkg::DRAM_BASE, soc_pkg::DRAM_TOP)) begin
      off = addr - soc_pkg::DRAM_BASE;
      return dram_shadow[off[9:2]];
    end
    return 32'h0;
  endfunction

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb);
    logic [31:0] off;
    logic [31:0] mask;
    mask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
    if (in_range(addr, soc_pkg::IRAM_BASE, soc_pkg::IRAM_TOP)) begin
      off = addr - soc_pkg::IRAM_BASE;
      iram_shadow[off[9:2]] = (iram_shadow[off[9:2]] & ~mask) | (wdata & mask);
    end else if (in_range(addr, soc_pkg::DRAM_BASE, soc_pkg::DRAM_TOP)) begin
      off = addr - soc_pkg::DRAM_BASE;
      dram_shadow[off[9:2]] = (dram_shadow[off[9:2]] & ~mask) | (wdata & mask);
    end
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, got %h", name, exp, act);
    end
  endtask

  // called on a falling edge, returns on the falling edge that shows ready.
  task automatic bus_access(input bit dport, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int done_at);
    if (dport) begin
      dmem_valid = 1'b1;
      dmem_addr = addr;
      dmem_wdata = wdata;
      dmem_wstrb = wstrb;
    end else begin
      imem_valid = 1'b1;
      imem_addr = addr;
      imem_wdata = wdata;
      imem_wstrb = wstrb;
    end
    do begin
      @(negedge clk_pll);
    end while (!(dport ? dmem_ready_o : imem_ready_o));
    rdata = dport ? dmem_rdata_o : imem_rdata_o;
    done_at = cycle;
    if (dport) begin
      dmem_valid = 1'b0;
    end else begin
      imem_valid = 1'b0;
    end
    if (wstrb != 4'h0) begin
      shadow_write(addr, wdata, wstrb);
    end
  endtask

  task automatic queue_read(input string name, input logic [31:0] addr,
                            input logic [31:0] data);
    rd_name_q.push_back(name);
    rd_addr_q.push_back(addr);
    rd_data_q.push_back(data);
  endtask

  task automatic write_word(input bit dport, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    logic [31:0] unused_rd;
    int unused_at;
    bus_access(dport, addr, wdata, wstrb, unused_rd, unused_at);
  endtask

  task automatic read_word(input bit dport, input logic [31:0] addr);
    logic [31:0] rd;
    int at;
    bus_access(dport, addr, 32'h0, 4'h0, rd, at);
    queue_read(dport ? "dmem_rdata_o" : "imem_rdata_o", addr, rd);
  endtask

  task automatic end_test(input string name);
    @(posedge clk_pll); // compare process drains the read queue here.
    @(negedge clk_pll);
    $display("test %s done, %0d errors", name, errors - test_errs);
    test_errs = errors;
  endtask

  always @(posedge clk_pll) begin
    while (rd_addr_q.size() > 0) begin
      check(rd_name_q.pop_front(), expected_word(rd_addr_q.pop_front()), rd_data_q.pop_front());
    end
  end

  always @(posedge clk_pll) begin
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd_d, rd_i, t0, t1, a0, a1, wd0, wd1, r;
    logic [31:0] dram_addrs [64];
    int da, ia, waited;
    rst = 1'b0;
    imem_valid = 1'b0;
    imem_addr = 32'h0;
    imem_wdata = 32'h0;
    imem_wstrb = 4'h0;
    dmem_valid = 1'b0;
    dmem_addr = 32'h0;
    dmem_wdata = 32'h0;
    dmem_wstrb = 4'h0;
    repeat (2) @(posedge clk_pll);
    @(negedge clk_pll);
    rst = 1'b1;

    check("imem_ready_o", 32'h0, {31'd0, imem_ready_o});
    check("dmem_ready_o", 32'h0, {31'd0, dmem_ready_o});
    check("timer_irq_o", 32'h0, {31'd0, timer_irq_o});
    end_test("reset");

    for (int k = 0; k < 8; k++) begin
      write_word(1'b0, 32'(k * 4), xorshift_next(), 4'hf);
    end
    for (int k = 0; k < 8; k++) begin
      write_word(1'b0, 32'(k * 4), xorshift_next(), 4'(k + 1)); // every strobe mix up to 4'h8.
    end
    for (int k = 0; k < 8; k++) begin
      read_word(1'b0, 32'(k * 4));
    end
    end_test("iram");

    for (int k = 0; k < 64; k++) begin
      r = xorshift_next();
      dram_addrs[k] = soc_pkg::DRAM_BASE + {22'd0, r[7:0], 2'b00};
      write_word(1'b1, dram_addrs[k], xorshift_next(), 4'hf);
      read_word(1'b1, dram_addrs[k]);
    end
    for (int k = 0; k < 64; k++) begin
      read_word(1'b1, dram_addrs[k]); // later writes may hit the same word.
    end
    end_test("dram");

    a0 = soc_pkg::DRAM_BASE + 32'h100;
    a1 = soc_pkg::DRAM_BASE + 32'h104;
    write_word(1'b1, a0, xorshift_next(), 4'hf);
    write_word(1'b1, a1, xorshift_next(), 4'hf);
    fork
      bus_access(1'b1, a0, 32'h0, 4'h0, rd_d, da);
      bus_access(1'b0, a1, 32'h0, 4'h0, rd_i, ia);
    join
    queue_read("dmem_rdata_o", a0, rd_d);
    queue_read("imem_rdata_o", a1, rd_i);
    checks++;
    if (da > ia) begin
      errors++;
      $display("data port finished in cycle %0d, after the instruction port in %0d", da, ia);
    end
    wd0 = xorshift_next();
    wd1 = xorshift_next();
    fork
      write_word(1'b1, a0, wd0, 4'hf);
      write_word(1'b0, a1, wd1, 4'h3);
    join
    read_word(1'b1, a0);
    read_word(1'b0, a1);
    end_test("contention");

    read_word(1'b0, 32'h0000_0800);
    read_word(1'b1, 32'h0000_0800);
    read_word(1'b0, 32'h0002_0010); // just past the timer registers.
    read_word(1'b1, 32'h8000_0000);
    write_word(1'b1, 32'h0001_0500, 32'hdead_beef, 4'hf); // same dram index bits as a0.
    write_word(1'b0, 32'h0000_0404, 32'hdead_beef, 4'hf); // same iram index bits as word 1.
    read_word(1'b1, a0);
    read_word(1'b0, 32'h0000_0004);
    end_test("unmapped");

    write_word(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_HI, 32'hffff_ffff, 4'hf);
    write_word(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_LO, 32'hffff_ffff, 4'hf);
    repeat (8) begin
      @(negedge clk_pll);
      check("timer_irq_o", 32'h0, {31'd0, timer_irq_o});
    end
    bus_access(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME_LO, 32'h0, 4'h0, t0, da);
    bus_access(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME_LO, 32'h0, 4'h0, t1, da);
    checks++;
    if (t1 <= t0) begin
      errors++;
      $display("mtime did not increase: first read %h, second read %h", t0, t1);
    end
    write_word(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_HI, 32'h0, 4'hf);
    write_word(1'b1, soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_LO, 32'h0, 4'hf);
    waited = 0;
    while (!timer_irq_o && waited < 4) begin
      @(negedge clk_pll);
      waited++;
    end
    check("timer_irq_o", 32'h1, {31'd0, timer_irq_o});
    repeat (8) begin
      @(negedge clk_pll);
      check("timer_irq_o", 32'h1, {31'd0, timer_irq_o});
    end
    end_test("timer");

    $display("closing: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hdl/soc_pkg.sv
hdl/bus_interconnect.sv
hdl/sram_block.sv
hdl/machine_timer.sv
hdl/soc_mem_top.sv
tb/tb_soc_mem_top.sv
